/* common/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// loads
`define MEM_OP_LB  6'h20
`define MEM_OP_LH  6'h21
`define MEM_OP_LWL 6'h22
`define MEM_OP_LW  6'h23
`define MEM_OP_LBU 6'h24
`define MEM_OP_LHU 6'h25
`define MEM_OP_LWR 6'h26

// stores
`define MEM_OP_SB  6'h28
`define MEM_OP_SH  6'h29
`define MEM_OP_SWL 6'h2a
`define MEM_OP_SW  6'h2b
`define MEM_OP_SWR 6'h2e

// no reservation kept, these act as LW / SW
`define MEM_OP_LL  6'h30
`define MEM_OP_SC  6'h38

// data ram depth in words, index from addr[9:2]
`define MEM_RAM_WORDS 256

`endif

/* common/memPkg.sv */
package memPkg;

    // data and address word
    typedef logic [31:0] wordT;

    // bit i enables lane i, bits 8i+7..8i
    typedef logic [3:0] byteEnT;

    // size code as driven on the bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } accessSizeT;

    // primary opcode, instr[31:26]
    typedef logic [5:0] opcodeT;

    // control carried from E into M
    typedef struct packed {
        opcodeT opcode;
        logic   memSel;  // 1 = slot 1
    } memTagT;

endpackage

/* hw/stageReg.sv */
`timescale 1ns/100ps

module stageReg #(
    parameter type payloadT = memPkg::wordT
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;  // flush beats stall
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* memControl/memControl.sv */
`timescale 1ns/100ps

`include "mem_macros.svh"

module memControl (
    input  logic               clk,
    input  logic               rst,
    input  memPkg::wordT       instr1E,
    input  memPkg::wordT       instr2E,
    input  memPkg::wordT       address1E,
    input  memPkg::wordT       address2E,
    input  memPkg::wordT       wdata1E,
    input  memPkg::wordT       wdata2E,
    input  logic               memSelE,
    input  logic               stallM,
    input  logic               flushM,
    input  memPkg::wordT       rtValueM,
    input  memPkg::wordT       ramRdataM,
    output memPkg::wordT       dataAddrE,
    output memPkg::byteEnT     byteEnE,
    output memPkg::wordT       writeDataE,
    output memPkg::accessSizeT dataSize,
    output memPkg::wordT       rdataM,
    output logic               addrErrorSw1,
    output logic               addrErrorLw1,
    output logic               addrErrorSw2,
    output logic               addrErrorLw2
);

    memPkg::opcodeT opE;
    memPkg::wordT   addrE;
    memPkg::wordT   srcE;
    logic [1:0]     offE;
    logic           wordOkE;
    logic           halfOkE;
    logic           swMisE;
    logic           lwMisE;

    memPkg::memTagT tagE;
    memPkg::memTagT tagM;
    memPkg::wordT   addrM;
    logic [1:0]     offM;
    logic [4:0]     shiftUpM;
    logic [4:0]     shiftDnM;
    memPkg::wordT   laneM;
    logic [7:0]     byteM;
    logic [15:0]    halfM;

    // slot select
    assign opE  = memSelE ? instr1E[31:26] : instr2E[31:26];
    assign addrE = memSelE ? address1E : address2E;
    assign srcE  = memSelE ? wdata1E : wdata2E;

    assign dataAddrE = addrE;
    assign offE      = addrE[1:0];
    assign wordOkE   = (offE == 2'b00);
    assign halfOkE   = ~offE[0];

    always_comb begin
        dataSize   = memPkg::SIZE_BYTE;
        byteEnE    = '0;
        writeDataE = '0;
        swMisE     = 1'b0;
        lwMisE     = 1'b0;
        case (opE)
            `MEM_OP_SW, `MEM_OP_SC: begin
                dataSize   = memPkg::SIZE_WORD;
                byteEnE    = {4{wordOkE}};
                writeDataE = srcE;
                swMisE     = ~wordOkE;
            end
            `MEM_OP_SWL: begin
                dataSize   = memPkg::SIZE_WORD;
                byteEnE    = 4'b1111 >> ~offE;  // lanes 0..off
                writeDataE = srcE >> {~offE, 3'b000};
            end
            `MEM_OP_SWR: begin
                dataSize   = memPkg::SIZE_WORD;
                byteEnE    = 4'b1111 << offE;  // lanes off..3
                writeDataE = srcE << {offE, 3'b000};
            end
            `MEM_OP_SH: begin
                dataSize   = memPkg::SIZE_HALF;
                byteEnE    = halfOkE ? (offE[1] ? 4'b1100 : 4'b0011) : 4'b0000;
                writeDataE = {2{srcE[15:0]}};
                swMisE     = ~halfOkE;
            end
            `MEM_OP_SB: begin
                dataSize   = memPkg::SIZE_BYTE;
                byteEnE    = 4'b0001 << offE;
                writeDataE = {4{srcE[7:0]}};
            end
            `MEM_OP_LW, `MEM_OP_LL: begin
                dataSize = memPkg::SIZE_WORD;
                lwMisE   = ~wordOkE;
            end
            `MEM_OP_LH, `MEM_OP_LHU: begin
                dataSize = memPkg::SIZE_HALF;
                lwMisE   = ~halfOkE;
            end
            `MEM_OP_LB, `MEM_OP_LBU: begin
                dataSize = memPkg::SIZE_BYTE;
            end
            `MEM_OP_LWL, `MEM_OP_LWR: begin
                dataSize = memPkg::SIZE_WORD;  // unaligned by design, never flagged
            end
            default: begin
                dataSize = memPkg::SIZE_BYTE;
            end
        endcase
    end

    // only the selected slot reports
    assign addrErrorSw1 = memSelE & swMisE;
    assign addrErrorLw1 = memSelE & lwMisE;
    assign addrErrorSw2 = ~memSelE & swMisE;
    assign addrErrorLw2 = ~memSelE & lwMisE;

    assign tagE = '{opcode: opE, memSel: memSelE};

    stageReg #(
        .payloadT(memPkg::memTagT)
    ) tagReg (
        .clk  (clk),
        .rst  (rst),
        .stall(stallM),
        .flush(flushM),
        .d    (tagE),
        .q    (tagM)
    );

    stageReg #(
        .payloadT(memPkg::wordT)
    ) addrReg (
        .clk  (clk),
        .rst  (rst),
        .stall(stallM),
        .flush(flushM),
        .d    (addrE),
        .q    (addrM)
    );

    assign offM     = addrM[1:0];
    assign shiftDnM = {offM, 3'b000};
    assign shiftUpM = {~offM, 3'b000};  // 8*(3-off)
    assign laneM    = ramRdataM >> shiftDnM;
    assign byteM    = laneM[7:0];
    assign halfM    = offM[1] ? ramRdataM[31:16] : ramRdataM[15:0];

    always_comb begin
        rdataM = '0;
        case (tagM.opcode)
            `MEM_OP_LW, `MEM_OP_LL: begin
                rdataM = ramRdataM;
            end
            `MEM_OP_LB: begin
                rdataM = {{24{byteM[7]}}, byteM};
            end
            `MEM_OP_LBU: begin
                rdataM = {24'b0, byteM};
            end
            `MEM_OP_LH: begin
                rdataM = {{16{halfM[15]}}, halfM};
            end
            `MEM_OP_LHU: begin
                rdataM = {16'b0, halfM};
            end
            `MEM_OP_LWL: begin
                rdataM = (ramRdataM << shiftUpM)
                       | (rtValueM & ~(32'hffff_ffff << shiftUpM));  // keep low bytes of rt
            end
            `MEM_OP_LWR: begin
                rdataM = (ramRdataM >> shiftDnM)
                       | (rtValueM & ~(32'hffff_ffff >> shiftDnM));  // keep high bytes of rt
            end
            default: begin
                rdataM = '0;
            end
        endcase
    end

endmodule

/* hw/dataRam.sv */
`timescale 1ns/100ps

`include "mem_macros.svh"

module dataRam (
    input  logic           clk,
    input  logic           en,
    input  memPkg::byteEnT byteEn,
    input  memPkg::wordT   addr,
    input  memPkg::wordT   wdata,
    output memPkg::wordT   rdata
);

    localparam int AW = $clog2(`MEM_RAM_WORDS);

    memPkg::wordT   mem [`MEM_RAM_WORDS];
    logic [AW-1:0]  idx;

    assign idx = addr[AW+1:2];  // word index

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byteEn[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // old word on a same-address write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
        end
    end

endmodule

/* hw/memStage.sv */
`timescale 1ns/100ps

module memStage (
    input  logic               clk,
    input  logic               rst,
    input  memPkg::wordT       instr1E,
    input  memPkg::wordT       instr2E,
    input  memPkg::wordT       address1E,
    input  memPkg::wordT       address2E,
    input  memPkg::wordT       wdata1E,
    input  memPkg::wordT       wdata2E,
    input  logic               memSelE,
    input  logic               stallM,
    input  logic               flushM,
    input  memPkg::wordT       rtValueM,
    output memPkg::wordT       rdataM,
    output logic               addrErrorSw1,
    output logic               addrErrorLw1,
    output logic               addrErrorSw2,
    output logic               addrErrorLw2,
    output memPkg::accessSizeT dataSize,
    output memPkg::wordT       dataAddrE,
    output memPkg::byteEnT     byteEnE
);

    memPkg::wordT writeDataE;
    memPkg::wordT ramRdataM;

    memControl ctrlInst (
        .clk         (clk),
        .rst         (rst),
        .instr1E     (instr1E),
        .instr2E     (instr2E),
        .address1E   (address1E),
        .address2E   (address2E),
        .wdata1E     (wdata1E),
        .wdata2E     (wdata2E),
        .memSelE     (memSelE),
        .stallM      (stallM),
        .flushM      (flushM),
        .rtValueM    (rtValueM),
        .ramRdataM   (ramRdataM),
        .dataAddrE   (dataAddrE),
        .byteEnE     (byteEnE),
        .writeDataE  (writeDataE),
        .dataSize    (dataSize),
        .rdataM      (rdataM),
        .addrErrorSw1(addrErrorSw1),
        .addrErrorLw1(addrErrorLw1),
        .addrErrorSw2(addrErrorSw2),
        .addrErrorLw2(addrErrorLw2)
    );

    dataRam ramInst (
        .clk   (clk),
        .en    (~stallM),  // hold read data while M is stalled
        .byteEn(byteEnE),
        .addr  (dataAddrE),
        .wdata (writeDataE),
        .rdata (ramRdataM)
    );

endmodule

/* verif/memStageRef.svh */
`ifndef MEM_STAGE_REF_SVH
`define MEM_STAGE_REF_SVH

logic [31:0] memModel [`MEM_RAM_WORDS];  // word model indexed by addr[9:2]

function automatic logic [3:0] expectedByteEn(logic [5:0] op, logic [1:0] off);
    int i;
    logic [3:0] be;
    for (i = 0; i < 4; i++) begin
        case (op)
            `MEM_OP_SB:             be[i] = (i == off);
            `MEM_OP_SH:             be[i] = !off[0] && (i / 2 == off / 2);
            `MEM_OP_SW, `MEM_OP_SC: be[i] = (off == 2'd0);
            `MEM_OP_SWL:            be[i] = (i <= off);
            `MEM_OP_SWR:            be[i] = (i >= off);
            default:                be[i] = 1'b0;
        endcase
    end
    return be;
endfunction

// bus size code of each access
function automatic logic [1:0] expectedSize(logic [5:0] op);
    case (op)
        `MEM_OP_LH, `MEM_OP_LHU, `MEM_OP_SH: return memPkg::SIZE_HALF;
        `MEM_OP_LW, `MEM_OP_LL, `MEM_OP_LWL, `MEM_OP_LWR,
        `MEM_OP_SW, `MEM_OP_SC, `MEM_OP_SWL, `MEM_OP_SWR: return memPkg::SIZE_WORD;
        default: return memPkg::SIZE_BYTE;
    endcase
endfunction

// {store flag, load flag}
function automatic logic [1:0] misalignFlags(logic [5:0] op, logic [1:0] off);
    case (op)
        `MEM_OP_SW, `MEM_OP_SC:  return {(off != 2'd0), 1'b0};
        `MEM_OP_SH:              return {off[0], 1'b0};
        `MEM_OP_LW, `MEM_OP_LL:  return {1'b0, (off != 2'd0)};
        `MEM_OP_LH, `MEM_OP_LHU: return {1'b0, off[0]};
        default:                 return 2'b00;
    endcase
endfunction

task automatic applyStore(logic [5:0] op, logic [31:0] addr, logic [31:0] data);
    int i;
    int src;
    logic [3:0] be;
    be = expectedByteEn(op, addr[1:0]);
    for (i = 0; i < 4; i++) begin
        case (op)
            `MEM_OP_SB:  src = 0;
            `MEM_OP_SH:  src = i % 2;
            `MEM_OP_SWL: src = i + 3 - addr[1:0];
            `MEM_OP_SWR: src = i - addr[1:0];
            default:     src = i;
        endcase
        if (be[i]) begin
            memModel[addr[9:2]][8*i +: 8] = data[8*src +: 8];
        end
    end
endtask

function automatic logic [31:0] loadResult(logic [5:0] op, logic [1:0] off,
                                           logic [31:0] word, logic [31:0] rt);
    int j;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] r;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];
    r = rt;  // lwl/lwr keep the rt bytes they do not replace
    case (op)
        `MEM_OP_LW, `MEM_OP_LL: r = word;
        `MEM_OP_LB:  r = {{24{b[7]}}, b};
        `MEM_OP_LBU: r = {24'h0, b};
        `MEM_OP_LH:  r = {{16{h[15]}}, h};
        `MEM_OP_LHU: r = {16'h0, h};
        `MEM_OP_LWL: begin
            for (j = 3 - off; j < 4; j++) begin
                r[8*j +: 8] = word[8*(j - 3 + off) +: 8];
            end
        end
        `MEM_OP_LWR: begin
            for (j = 0; j <= 3 - off; j++) begin
                r[8*j +: 8] = word[8*(j + off) +: 8];
            end
        end
        default: r = '0;
    endcase
    return r;
endfunction

`endif

/* verif/memStageTb.sv */
`timescale 1ns/100ps

`include "mem_macros.svh"

module memStageTb;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 4 * 4 + 4 * 6 + 2 * 3 + 4 * 8 + 8 * 3 + 9;  // ops per section

    logic               clk = 1'b0;
    logic               rst;
    memPkg::wordT       instr1E;
    memPkg::wordT       instr2E;
    memPkg::wordT       address1E;
    memPkg::wordT       address2E;
    memPkg::wordT       wdata1E;
    memPkg::wordT       wdata2E;
    logic               memSelE;
    logic               stallM;
    logic               flushM;
    memPkg::wordT       rtValueM;
    memPkg::wordT       rdataM;
    logic               addrErrorSw1;
    logic               addrErrorLw1;
    logic               addrErrorSw2;
    logic               addrErrorLw2;
    memPkg::accessSizeT dataSize;
    memPkg::wordT       dataAddrE;
    memPkg::byteEnT     byteEnE;

    integer      seed = 32'h8763;
    logic [5:0]  mOp;  // expected M-stage state
    logic [1:0]  mOff;
    logic [31:0] mWord;

    `include "memStageRef.svh"

    memStage dut_i (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    // other slot gets random junk
    task automatic issueOp(input logic [5:0] op, input logic [7:0] word, input logic [1:0] off,
                           input memPkg::wordT data, input logic sel);
        @(negedge clk);
        instr1E   = $random(seed);
        instr2E   = $random(seed);
        address1E = $random(seed);
        address2E = $random(seed);
        wdata1E   = $random(seed);
        wdata2E   = $random(seed);
        rtValueM  = $random(seed);
        memSelE   = sel;
        stallM    = 1'b0;
        flushM    = 1'b0;
        if (sel) begin
            instr1E[31:26] = op;
            address1E[9:0] = {word, off};
            wdata1E        = data;
        end else begin
            instr2E[31:26] = op;
            address2E[9:0] = {word, off};
            wdata2E        = data;
        end
    endtask

    initial begin : compare
        logic [5:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  mis;
        forever begin
            @(negedge clk);
            #(PERIOD / 2 - 2);  // just before the rising edge
            if (rst) begin
                mOp = '0;
            end else begin
                op   = memSelE ? instr1E[31:26] : instr2E[31:26];
                addr = memSelE ? address1E : address2E;
                data = memSelE ? wdata1E : wdata2E;
                mis  = misalignFlags(op, addr[1:0]);
                checkValue("dataAddrE", dataAddrE, addr);
                checkValue("dataSize", dataSize, expectedSize(op));
                checkValue("byteEnE", byteEnE, expectedByteEn(op, addr[1:0]));
                checkValue("addrErrorSw1", addrErrorSw1, memSelE & mis[1]);
                checkValue("addrErrorLw1", addrErrorLw1, memSelE & mis[0]);
                checkValue("addrErrorSw2", addrErrorSw2, !memSelE & mis[1]);
                checkValue("addrErrorLw2", addrErrorLw2, !memSelE & mis[0]);
                checkValue("rdataM", rdataM, loadResult(mOp, mOff, mWord, rtValueM));
                if (flushM) begin
                    mOp = '0;
                end else if (!stallM) begin
                    mOp  = op;
                    mOff = addr[1:0];
                end
                if (!stallM) begin
                    mWord = memModel[addr[9:2]];  // ram reads old word
                end
                applyStore(op, addr, data);
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_OPS + 10) * PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int           k;
        int           off;
        logic [5:0]   op;
        memPkg::wordT d;
        {instr1E, instr2E, address1E, address2E} = '0;
        {wdata1E, wdata2E, rtValueM} = '0;
        {memSelE, stallM, flushM} = '0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        #(PERIOD / 2 - 2);
        checkValue("rdataM", rdataM, 32'h0);
        checkValue("byteEnE", byteEnE, 32'h0);
        checkValue("addrError", {addrErrorSw1, addrErrorLw1, addrErrorSw2, addrErrorLw2}, 32'h0);

        for (k = 0; k < 4; k++) begin
            d = $random(seed);
            issueOp(`MEM_OP_SW, 8'(k), 2'd0, d, k[0]);
            issueOp(`MEM_OP_LW, 8'(k), 2'd0, 32'h0, !k[0]);
            issueOp(`MEM_OP_SC, 8'(k + 4), 2'd0, ~d, k[0]);
            issueOp(`MEM_OP_LL, 8'(k + 4), 2'd0, 32'h0, k[0]);
        end

        for (off = 0; off < 4; off++) begin
            issueOp(`MEM_OP_SW, 8'(32 + off), 2'd0, $random(seed), 1'b1);
            d    = $random(seed);
            d[7] = off[0];  // odd lanes negative
            issueOp(`MEM_OP_SB, 8'(32 + off), 2'(off), d, 1'b0);
            issueOp(`MEM_OP_LB, 8'(32 + off), 2'(off), 32'h0, 1'b1);
            issueOp(`MEM_OP_LBU, 8'(32 + off), 2'(off), 32'h0, 1'b0);
            issueOp(`MEM_OP_LH, 8'(32 + off), 2'(off & 2), 32'h0, 1'b1);
            issueOp(`MEM_OP_LHU, 8'(32 + off), 2'(off & 2), 32'h0, 1'b0);
        end
        for (off = 0; off < 4; off += 2) begin
            d     = $random(seed);
            d[15] = off[1];
            issueOp(`MEM_OP_SH, 8'd40, 2'(off), d, 1'b1);
            issueOp(`MEM_OP_LH, 8'd40, 2'(off), 32'h0, 1'b0);
            issueOp(`MEM_OP_LHU, 8'd40, 2'(off), 32'h0, 1'b1);
        end

        for (off = 0; off < 4; off++) begin
            issueOp(`MEM_OP_SW, 8'(48 + off), 2'd0, $random(seed), 1'b1);
            issueOp(`MEM_OP_SWL, 8'(48 + off), 2'(off), $random(seed), 1'b0);
            issueOp(`MEM_OP_LWL, 8'(48 + off), 2'(off), 32'h0, 1'b1);
            issueOp(`MEM_OP_LWR, 8'(48 + off), 2'(off), 32'h0, 1'b0);
            issueOp(`MEM_OP_SW, 8'(52 + off), 2'd0, $random(seed), 1'b0);
            issueOp(`MEM_OP_SWR, 8'(52 + off), 2'(off), $random(seed), 1'b1);
            issueOp(`MEM_OP_LWL, 8'(52 + off), 2'(off), 32'h0, 1'b0);
            issueOp(`MEM_OP_LWR, 8'(52 + off), 2'(off), 32'h0, 1'b1);
        end

        for (k = 0; k < 8; k++) begin
            case (2'($random(seed)))
                2'd0:    op = `MEM_OP_SW;
                2'd1:    op = `MEM_OP_SH;
                2'd2:    op = `MEM_OP_LW;
                default: op = `MEM_OP_LH;
            endcase
            off = (op == `MEM_OP_SH || op == `MEM_OP_LH) ? 1 + 2 * k[0] : 1 + k % 3;
            issueOp(`MEM_OP_SW, 8'(64 + k), 2'd0, $random(seed), 1'b1);
            issueOp(op, 8'(64 + k), 2'(off), $random(seed), 1'($random(seed)));
            issueOp(`MEM_OP_LW, 8'(64 + k), 2'd0, 32'h0, 1'b1);  // word untouched
        end

        issueOp(`MEM_OP_SW, 8'd80, 2'd0, $random(seed), 1'b1);
        issueOp(`MEM_OP_LW, 8'd80, 2'd0, 32'h0, 1'b0);
        repeat (3) begin
            issueOp(6'h00, 8'd0, 2'd0, 32'h0, 1'b0);
            stallM = 1'b1;
        end
        issueOp(6'h00, 8'd0, 2'd0, 32'h0, 1'b0);
        issueOp(`MEM_OP_LW, 8'd80, 2'd0, 32'h0, 1'b1);
        flushM = 1'b1;  // load never reaches M
        issueOp(6'h00, 8'd0, 2'd0, 32'h0, 1'b0);
        issueOp(6'h00, 8'd0, 2'd0, 32'h0, 1'b1);
        @(negedge clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
+incdir+verif
common/memPkg.sv
hw/stageReg.sv
memControl/memControl.sv
hw/dataRam.sv
hw/memStage.sv
verif/memStageTb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - common
      - verif
    files:
      - common/memPkg.sv
      - hw/stageReg.sv
      - memControl/memControl.sv
      - hw/dataRam.sv
      - hw/memStage.sv
      - target: test
        files:
          - verif/memStageTb.sv
